// File: include/integral_defs.svh
`ifndef INTEGRAL_DEFS_SVH
`define INTEGRAL_DEFS_SVH

// frame geometry, fixed at build time

// pixels per row
`define INT_COLS 15

// rows per frame
`define INT_ROWS 8

// input pixel width in bits
`define INT_PIX_W 8

// integral result width, sums wrap at this width
`define INT_SUM_W 16

`endif

// File: hdl/integral_pkg.sv
`include "integral_defs.svh"

package integral_pkg;

  // column index, one extra value of headroom keeps the width sane
  typedef logic [$clog2(`INT_COLS + 1)-1:0] col_idx_t;

  // one full row of raw pixels, column 0 in the low slot
  typedef logic [`INT_COLS-1:0][`INT_PIX_W-1:0] pix_row_t;

  // input beat
  typedef struct packed {
    logic [`INT_PIX_W-1:0] pix;
  } pix_beat_t;

  // output beat with position flags
  typedef struct packed {
    logic [`INT_SUM_W-1:0] sum;
    logic                  row_last;
    logic                  frame_last;
  } int_beat_t;

  // row sequencing states
  typedef enum logic [2:0] {
    idle,
    wait_row,
    load_row,
    sum_phase,
    cum_phase,
    finish,
    done
  } row_state_t;

endpackage

// File: hdl/pixel_ingress.sv
`timescale 1ns/1ps
`include "integral_defs.svh"

module pixel_ingress
  import integral_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  pix_beat_t i_pix,
  input  logic      i_pix_valid,
  output logic      o_pix_ready,
  input  logic      i_ld_en,
  output logic      o_row_full,
  output pix_row_t  o_row
);

  localparam int COLS = `INT_COLS;

  col_idx_t wr_col;
  logic     row_full;
  pix_row_t row_buf;
  logic     pix_xfer;

  // no space while a complete row waits for the controller
  assign o_pix_ready = ~row_full;
  assign pix_xfer    = i_pix_valid & o_pix_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_col   <= '0;
      row_full <= 1'b0;
    end else if (pix_xfer) begin
      if (wr_col == col_idx_t'(COLS - 1)) begin
        // last column of the row
        wr_col   <= '0;
        row_full <= 1'b1;
      end else begin
        wr_col <= wr_col + 1'b1;
      end
    end else if (i_ld_en) begin
      // datapath copies the buffer this cycle
      row_full <= 1'b0;
    end
  end

  // row storage
  always_ff @(posedge clk) begin
    if (pix_xfer) begin
      row_buf[wr_col] <= i_pix.pix;
    end
  end

  assign o_row_full = row_full;
  assign o_row      = row_buf;

endmodule

// File: hdl/row_controller.sv
`timescale 1ns/1ps
`include "integral_defs.svh"

module row_controller
  import integral_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_row_full,
  input  logic       i_out_ready,
  output logic       o_ld_en,
  output logic       o_sum_en,
  output logic       o_cum_en,
  output col_idx_t   o_col_idx,
  output logic       o_first_row,
  output logic       o_row_last,
  output logic       o_frame_last,
  output logic       o_frame_done,
  output row_state_t o_state
);

  localparam int COLS  = `INT_COLS;
  localparam int ROWS  = `INT_ROWS;
  localparam int ROW_W = $clog2(ROWS + 1);

  row_state_t       state;
  row_state_t       next_state;
  col_idx_t         col_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic             col_last;
  logic             row_is_last;

  assign col_last    = (col_cnt == col_idx_t'(COLS - 1));
  assign row_is_last = (row_cnt == ROW_W'(ROWS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      idle:      next_state = wait_row;
      wait_row:  next_state = i_row_full ? load_row : wait_row;
      load_row:  next_state = sum_phase;
      sum_phase: next_state = col_last ? cum_phase : sum_phase;
      cum_phase: begin
        // leave only on the accepted handoff of the last column
        if (i_out_ready && col_last) begin
          next_state = row_is_last ? finish : wait_row;
        end
      end
      finish:    next_state = done;
      done:      next_state = idle;
      default:   next_state = idle;
    endcase
  end

  // column and row counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else begin
      case (state)
        sum_phase: col_cnt <= col_last ? '0 : col_cnt + 1'b1;
        cum_phase: begin
          if (i_out_ready) begin
            if (col_last) begin
              col_cnt <= '0;
              row_cnt <= row_is_last ? '0 : row_cnt + 1'b1;
            end else begin
              col_cnt <= col_cnt + 1'b1;
            end
          end
        end
        default:   col_cnt <= '0;
      endcase
    end
  end

  always_comb begin
    o_ld_en      = 1'b0;
    o_sum_en     = 1'b0;
    o_cum_en     = 1'b0;
    o_frame_done = 1'b0;
    case (state)
      load_row:  o_ld_en = 1'b1;
      sum_phase: o_sum_en = 1'b1;
      // a step only happens when the skid buffer can take it
      cum_phase: o_cum_en = i_out_ready;
      finish:    o_frame_done = 1'b1;
      default:   o_ld_en = 1'b0;
    endcase
  end

  assign o_col_idx    = col_cnt;
  assign o_first_row  = (row_cnt == '0);
  assign o_row_last   = col_last;
  assign o_frame_last = col_last & row_is_last;
  assign o_state      = state;

endmodule

// File: hdl/integral_datapath.sv
`timescale 1ns/1ps
`include "integral_defs.svh"

module integral_datapath
  import integral_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  pix_row_t  i_row,
  input  logic      i_ld_en,
  input  logic      i_sum_en,
  input  logic      i_cum_en,
  input  col_idx_t  i_col_idx,
  input  logic      i_first_row,
  input  logic      i_row_last,
  input  logic      i_frame_last,
  output int_beat_t o_beat,
  output logic      o_beat_valid
);

  localparam int COLS  = `INT_COLS;
  localparam int SUM_W = `INT_SUM_W;

  // working row holds pixels, then horizontal prefix sums
  logic [SUM_W-1:0] work_row [COLS];
  // integral values of the previous row
  logic [SUM_W-1:0] line_buf [COLS];

  logic [SUM_W-1:0] left_sum;
  logic [SUM_W-1:0] above_sum;
  logic [SUM_W-1:0] cum_sum;

  // column 0 has nothing to its left
  assign left_sum = (i_col_idx == '0) ? '0 : work_row[i_col_idx - 1'b1];

  // first row of a frame starts from zero, so stale line data is ignored
  assign above_sum = i_first_row ? '0 : line_buf[i_col_idx];

  // wraps modulo 2**SUM_W
  assign cum_sum = work_row[i_col_idx] + above_sum;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int c = 0; c < COLS; c++) begin
        work_row[c] <= '0;
      end
    end else if (i_ld_en) begin
      for (int c = 0; c < COLS; c++) begin
        work_row[c] <= SUM_W'(i_row[c]);
      end
    end else if (i_sum_en) begin
      // left neighbour already holds its prefix sum
      work_row[i_col_idx] <= work_row[i_col_idx] + left_sum;
    end
  end

  // result becomes the row above for the next row
  always_ff @(posedge clk) begin
    if (i_cum_en) begin
      line_buf[i_col_idx] <= cum_sum;
    end
  end

  always_comb begin
    o_beat.sum        = cum_sum;
    o_beat.row_last   = i_row_last;
    o_beat.frame_last = i_frame_last;
  end

  // each enabled step is one beat into the skid buffer
  assign o_beat_valid = i_cum_en;

endmodule

// File: hdl/stream_skid.sv
`timescale 1ns/1ps

module stream_skid #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t i_data,
  input  logic     i_valid,
  output logic     o_ready,
  output payload_t o_data,
  output logic     o_valid,
  input  logic     i_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     out_load;
  logic     in_xfer;

  // ready comes straight from a flop
  assign o_ready  = ~skid_valid;
  assign in_xfer  = i_valid & o_ready;
  // output register is free or draining this cycle
  assign out_load = ~o_valid | i_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_load) begin
      if (skid_valid) begin
        o_valid    <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        o_valid <= in_xfer;
      end
    end else if (in_xfer) begin
      // output stalled, park the new beat
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      o_data <= skid_valid ? skid_data : i_data;
    end
    if (!out_load && in_xfer) begin
      skid_data <= i_data;
    end
  end

endmodule

// File: hdl/integral_top.sv
`timescale 1ns/1ps

module integral_top
  import integral_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  pix_beat_t i_pix,
  input  logic      i_pix_valid,
  output logic      o_pix_ready,
  output int_beat_t o_int,
  output logic      o_int_valid,
  input  logic      i_int_ready,
  output logic      o_frame_done
);

  logic       row_full;
  pix_row_t   row;
  logic       ld_en;
  logic       sum_en;
  logic       cum_en;
  col_idx_t   col_idx;
  logic       first_row;
  logic       row_last;
  logic       frame_last;
  row_state_t ctrl_state;
  int_beat_t  beat;
  logic       beat_valid;
  logic       skid_ready;

  pixel_ingress pixel_ingress_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix       (i_pix),
    .i_pix_valid (i_pix_valid),
    .o_pix_ready (o_pix_ready),
    .i_ld_en     (ld_en),
    .o_row_full  (row_full),
    .o_row       (row)
  );

  row_controller row_controller_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_row_full   (row_full),
    .i_out_ready  (skid_ready),
    .o_ld_en      (ld_en),
    .o_sum_en     (sum_en),
    .o_cum_en     (cum_en),
    .o_col_idx    (col_idx),
    .o_first_row  (first_row),
    .o_row_last   (row_last),
    .o_frame_last (frame_last),
    .o_frame_done (o_frame_done),
    .o_state      (ctrl_state)
  );

  integral_datapath integral_datapath_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_row        (row),
    .i_ld_en      (ld_en),
    .i_sum_en     (sum_en),
    .i_cum_en     (cum_en),
    .i_col_idx    (col_idx),
    .i_first_row  (first_row),
    .i_row_last   (row_last),
    .i_frame_last (frame_last),
    .o_beat       (beat),
    .o_beat_valid (beat_valid)
  );

  // output register stage, absorbs back-pressure
  stream_skid #(
    .payload_t (int_beat_t)
  ) stream_skid_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_data  (beat),
    .i_valid (beat_valid),
    .o_ready (skid_ready),
    .o_data  (o_int),
    .o_valid (o_int_valid),
    .i_ready (i_int_ready)
  );

endmodule

// File: bench/integral_assert.sv
`timescale 1ns/1ps

module integral_assert
  import integral_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input pix_beat_t  i_pix,
  input logic       i_pix_valid,
  input logic       i_pix_ready,
  input int_beat_t  i_int,
  input logic       i_int_valid,
  input logic       i_int_ready,
  input logic       i_frame_done,
  input logic       i_sum_en,
  input logic       i_cum_en,
  input row_state_t i_state
);

  int fail_cnt = 0;

  // stalled beats hold still on both channels
  pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
      i_pix_valid && !i_pix_ready |=> i_pix_valid && $stable(i_pix))
    else begin
      $error("input beat changed or dropped while stalled");
      fail_cnt++;
    end

  int_hold: assert property (@(posedge clk) disable iff (!rst_n)
      i_int_valid && !i_int_ready |=> i_int_valid && $stable(i_int))
    else begin
      $error("output beat changed or dropped while stalled");
      fail_cnt++;
    end

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      i_frame_done |=> !i_frame_done)
    else begin
      $error("frame done is not a single cycle pulse");
      fail_cnt++;
    end

  phase_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(i_sum_en && i_cum_en))
    else begin
      $error("sum and cum phases enabled together");
      fail_cnt++;
    end

  reset_quiet: assert property (@(posedge clk)
      !rst_n |=> !i_int_valid && !i_frame_done && !i_sum_en && !i_cum_en
                 && i_pix_ready && i_state == idle)
    else begin
      $error("outputs active right after reset");
      fail_cnt++;
    end

endmodule

bind integral_top integral_assert integral_assert_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .i_pix        (i_pix),
  .i_pix_valid  (i_pix_valid),
  .i_pix_ready  (o_pix_ready),
  .i_int        (o_int),
  .i_int_valid  (o_int_valid),
  .i_int_ready  (i_int_ready),
  .i_frame_done (o_frame_done),
  .i_sum_en     (sum_en),
  .i_cum_en     (cum_en),
  .i_state      (ctrl_state)
);

// File: bench/integral_checker.sv
`timescale 1ns/1ps
`include "integral_defs.svh"

module integral_checker
  import integral_pkg::*;
#(
  parameter int NUM_FRAMES = 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  int_beat_t             i_int,
  input  logic                  i_int_valid,
  input  logic                  i_int_ready,
  input  logic                  i_frame_done,
  input  logic [`INT_SUM_W-1:0] i_exp [NUM_FRAMES*`INT_ROWS*`INT_COLS],
  output int                    o_errors,
  output int                    o_beats,
  output int                    o_frames
);

  localparam int COLS        = `INT_COLS;
  localparam int ROWS        = `INT_ROWS;
  localparam int FRAME_BEATS = ROWS * COLS;
  localparam int TOTAL       = NUM_FRAMES * FRAME_BEATS;

  int cur_frame;
  int cur_row;
  int cur_col;

  task automatic compare_beat();
    logic [`INT_SUM_W-1:0] exp_sum;
    logic                  exp_row_last;
    logic                  exp_frame_last;
    exp_row_last   = (cur_col == COLS - 1);
    exp_frame_last = exp_row_last && (cur_row == ROWS - 1);
    if (o_beats >= TOTAL) begin
      $display("%0t: extra output beat after the last frame, sum %0d", $time, i_int.sum);
      o_errors++;
    end else begin
      exp_sum = i_exp[o_beats];
      if (i_int.sum !== exp_sum) begin
        $display("MISMATCH %0t: frame %0d row %0d col %0d sum %0d expected %0d",
                 $time, cur_frame, cur_row, cur_col, i_int.sum, exp_sum);
        o_errors++;
      end
      if (i_int.row_last !== exp_row_last || i_int.frame_last !== exp_frame_last) begin
        $display("MISMATCH %0t: frame %0d row %0d col %0d flags %b%b expected %b%b",
                 $time, cur_frame, cur_row, cur_col, i_int.row_last, i_int.frame_last,
                 exp_row_last, exp_frame_last);
        o_errors++;
      end
    end
    o_beats++;
    // raster position of the next beat
    if (cur_col == COLS - 1) begin
      cur_col = 0;
      if (cur_row == ROWS - 1) begin
        cur_row = 0;
        cur_frame++;
      end else begin
        cur_row++;
      end
    end else begin
      cur_col++;
    end
  endtask

  task automatic count_frame_done();
    int hi;
    hi = (o_frames + 1) * FRAME_BEATS;
    // up to two beats of the frame may still sit in the skid buffer
    if (o_beats > hi || o_beats < hi - 2) begin
      $display("%0t: frame done %0d came with %0d beats out, expected %0d to %0d",
               $time, o_frames, o_beats, hi - 2, hi);
      o_errors++;
    end
    o_frames++;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      cur_frame = 0;
      cur_row   = 0;
      cur_col   = 0;
      o_errors  = 0;
      o_beats   = 0;
      o_frames  = 0;
    end else begin
      if (i_int_valid && i_int_ready) begin
        compare_beat();
      end
      if (i_frame_done) begin
        count_frame_done();
      end
    end
  end

endmodule

// File: bench/integral_tb.sv
`timescale 1ns/1ps
`include "integral_defs.svh"

module integral_tb
  import integral_pkg::*;
();

  localparam int COLS           = `INT_COLS;
  localparam int ROWS           = `INT_ROWS;
  localparam int PIX_W          = `INT_PIX_W;
  localparam int SUM_W          = `INT_SUM_W;
  localparam int NUM_FRAMES     = 3;
  localparam int TOTAL          = NUM_FRAMES * ROWS * COLS;
  localparam int TIMEOUT_CYCLES = 4 * NUM_FRAMES * ROWS * 3 * COLS + 200;
  localparam logic [31:0] SEED  = 32'd35241;

  logic      clk = 1'b0;
  logic      rst_n;
  pix_beat_t pix;
  logic      pix_valid;
  logic      pix_ready;
  int_beat_t int_beat;
  logic      int_valid;
  logic      int_ready = 1'b0;
  logic      frame_done;

  logic [PIX_W-1:0] frame_pix [NUM_FRAMES][ROWS][COLS];
  logic [SUM_W-1:0] exp_vals [TOTAL];
  logic [31:0]      pix_state;
  logic [31:0]      rdy_state;
  int               out_frames = 0;
  int               cycle_cnt;
  int               chk_errors;
  int               chk_beats;
  int               chk_frames;
  int               assert_errors;
  int               end_errors;

  always #20 clk = ~clk;

  integral_top integral_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_pix        (pix),
    .i_pix_valid  (pix_valid),
    .o_pix_ready  (pix_ready),
    .o_int        (int_beat),
    .o_int_valid  (int_valid),
    .i_int_ready  (int_ready),
    .o_frame_done (frame_done)
  );

  integral_checker #(
    .NUM_FRAMES (NUM_FRAMES)
  ) integral_checker_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_int        (int_beat),
    .i_int_valid  (int_valid),
    .i_int_ready  (int_ready),
    .i_frame_done (frame_done),
    .i_exp        (exp_vals),
    .o_errors     (chk_errors),
    .o_beats      (chk_beats),
    .o_frames     (chk_frames)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // sum over the rectangle from the frame origin to (r, c) modulo 2**SUM_W
  function automatic logic [SUM_W-1:0] ref_integral(input int f, input int r, input int c);
    logic [SUM_W-1:0] acc;
    acc = '0;
    for (int rr = 0; rr <= r; rr++) begin
      for (int cc = 0; cc <= c; cc++) begin
        acc = acc + SUM_W'(frame_pix[f][rr][cc]);
      end
    end
    return acc;
  endfunction

  // frame 0 all ones, last frame all max, random in between
  task automatic build_frames();
    for (int f = 0; f < NUM_FRAMES; f++) begin
      for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
          pix_state = lcg_next(pix_state);
          if (f == 0) begin
            frame_pix[f][r][c] = PIX_W'(1);
          end else if (f == NUM_FRAMES - 1) begin
            frame_pix[f][r][c] = '1;
          end else begin
            frame_pix[f][r][c] = PIX_W'(pix_state >> 16);
          end
          exp_vals[(f * ROWS + r) * COLS + c] = ref_integral(f, r, c);
        end
      end
    end
  endtask

  // drive one beat and hold it until it transfers
  task automatic send_pixel(input logic [PIX_W-1:0] val, input bit gaps);
    if (gaps) begin
      pix_state = lcg_next(pix_state);
      while (pix_state[17:16] == 2'd0) begin
        pix_valid <= 1'b0;
        @(posedge clk);
        pix_state = lcg_next(pix_state);
      end
    end
    pix_valid <= 1'b1;
    pix.pix   <= val;
    @(posedge clk);
    while (!pix_ready) begin
      @(posedge clk);
    end
  endtask

  // no back-pressure until the first frame has left
  always @(posedge clk) begin
    if (!rst_n) begin
      rdy_state = lcg_next(lcg_next(SEED));
      int_ready <= 1'b0;
    end else begin
      if (int_valid && int_ready && int_beat.frame_last) begin
        out_frames <= out_frames + 1;
      end
      rdy_state = lcg_next(rdy_state);
      int_ready <= (out_frames == 0) || (rdy_state[18:17] != 2'd0);
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    pix        = '0;
    pix_valid  = 1'b0;
    end_errors = 0;
    pix_state  = SEED;
    build_frames();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
          send_pixel(frame_pix[f][r][c], f != 0);
        end
      end
    end
    pix_valid <= 1'b0;
    wait (chk_frames == NUM_FRAMES);
    wait (chk_beats >= TOTAL);
    // room for any stray beat or pulse to show up
    repeat (8) @(posedge clk);
    if (chk_beats != TOTAL) begin
      $display("wrong number of output beats: %0d received, %0d expected", chk_beats, TOTAL);
      end_errors++;
    end
    if (chk_frames != NUM_FRAMES) begin
      $display("wrong number of frame done pulses: %0d, expected %0d", chk_frames, NUM_FRAMES);
      end_errors++;
    end
    assert_errors = integral_top_inst.integral_assert_inst.fail_cnt;
    $display("errors: checker %0d, assertions %0d, end of run %0d",
             chk_errors, assert_errors, end_errors);
    if (chk_errors == 0 && assert_errors == 0 && end_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
hdl/integral_pkg.sv
hdl/pixel_ingress.sv
hdl/row_controller.sv
hdl/integral_datapath.sv
hdl/stream_skid.sv
hdl/integral_top.sv
bench/integral_assert.sv
bench/integral_checker.sv
bench/integral_tb.sv

// File: Bender.yml
package:
  name: integral_image

export_include_dirs:
  - include

sources:
  - files:
      - hdl/integral_pkg.sv
      - hdl/pixel_ingress.sv
      - hdl/row_controller.sv
      - hdl/integral_datapath.sv
      - hdl/stream_skid.sv
      - hdl/integral_top.sv
  - target: test
    files:
      - bench/integral_assert.sv
      - bench/integral_checker.sv
      - bench/integral_tb.sv
